//--- Bender.yml
package:
  name: rv_cpu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/rv_pkg.sv
      - logic/reg_bank.sv
      - logic/alu.sv
      - logic/datapath.sv
      - logic/control_fsm.sv
      - logic/cpu.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/rv_golden.sv
      - tb/tb_cpu.sv

//--- include/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// ****************************************************************************
// Widths and sizes
// ****************************************************************************

// Machine word.
`define RV_XLEN 32

// Register file.
`define RV_REG_ADDR_W 5
`define RV_REG_COUNT 32

// Byte address into the data memory.
`define RV_DMEM_ADDR_W 10

// ****************************************************************************
// Opcodes
// ****************************************************************************

// Register-register ALU.
`define RV_OPC_R_TYPE 7'b0110011

// Register-immediate ALU.
`define RV_OPC_I_TYPE 7'b0010011

`define RV_OPC_LOAD 7'b0000011

`endif

//--- logic/alu.sv
`include "rv_macros.svh"

module alu (
    input  rv_pkg::alu_op_t     op,
    input  logic [`RV_XLEN-1:0] operand_a,
    input  logic [`RV_XLEN-1:0] operand_b,
    output logic [`RV_XLEN-1:0] result,
    output logic                negative,
    output logic                overflow,
    output logic                zero
);
    import rv_pkg::*;

    localparam int SHAMT_W = $clog2(`RV_XLEN);
    localparam int MSB = `RV_XLEN - 1;

    logic [`RV_XLEN-1:0] sum;
    logic [`RV_XLEN-1:0] difference;
    logic [SHAMT_W-1:0]  shamt;
    logic                less_signed;
    logic                less_unsigned;

    assign sum           = operand_a + operand_b;
    assign difference    = operand_a - operand_b;
    assign shamt         = operand_b[SHAMT_W-1:0];
    assign less_signed   = $signed(operand_a) < $signed(operand_b);
    assign less_unsigned = operand_a < operand_b;

    always_comb begin
        case (op)
            alu_add:  result = sum;
            alu_sub:  result = difference;
            alu_sll:  result = operand_a << shamt;
            alu_slt:  result = {{(`RV_XLEN-1){1'b0}}, less_signed};
            alu_sltu: result = {{(`RV_XLEN-1){1'b0}}, less_unsigned};
            alu_xor:  result = operand_a ^ operand_b;
            alu_srl:  result = operand_a >> shamt;
            alu_or:   result = operand_a | operand_b;
            alu_and:  result = operand_a & operand_b;
            default:  result = sum;
        endcase
    end

    // Signed overflow only means something for add and sub.
    always_comb begin
        case (op)
            alu_add:
                overflow = (operand_a[MSB] == operand_b[MSB]) && (sum[MSB] != operand_a[MSB]);
            alu_sub:
                overflow = (operand_a[MSB] != operand_b[MSB]) &&
                           (difference[MSB] != operand_a[MSB]);
            default:
                overflow = 1'b0;
        endcase
    end

    assign negative = result[MSB];
    assign zero     = (result == '0);

endmodule

//--- logic/control_fsm.sv
`include "rv_macros.svh"

module control_fsm (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [6:0]          opcode,
    input  logic [2:0]          funct3,
    input  logic                funct7_sub,
    input  logic                mem_ack,
    output rv_pkg::alu_op_t     alu_op,
    output logic                alu_src_reg,
    output logic                reg_write,
    output logic                pc_step,
    output logic                mem_req,
    output logic                data_latch,
    output logic                load_select,
    output rv_pkg::load_width_t load_width
);
    import rv_pkg::*;

    ctrl_state_t state;
    alu_op_t     decoded_op;
    load_width_t decoded_width;
    logic        is_r_type;
    logic        is_i_type;
    logic        is_load;

    // ************************************************************************
    // Instruction decode
    // ************************************************************************

    assign is_r_type = (opcode == `RV_OPC_R_TYPE);
    assign is_i_type = (opcode == `RV_OPC_I_TYPE);
    assign is_load   = (opcode == `RV_OPC_LOAD);

    always_comb begin
        case (funct3)
            3'd0:    decoded_op = (is_r_type && funct7_sub) ? alu_sub : alu_add;
            3'd1:    decoded_op = alu_sll;
            3'd2:    decoded_op = alu_slt;
            3'd3:    decoded_op = alu_sltu;
            3'd4:    decoded_op = alu_xor;
            3'd5:    decoded_op = alu_srl;
            3'd6:    decoded_op = alu_or;
            default: decoded_op = alu_and;
        endcase
    end

    always_comb begin
        case (funct3)
            3'd0:    decoded_width = lw_byte;
            3'd1:    decoded_width = lw_half;
            default: decoded_width = lw_word;
        endcase
    end

    // ************************************************************************
    // Sequencer
    // ************************************************************************

    // Read data is captured on the same edge that sees the ack.
    assign data_latch = (state == st_mem_request) && mem_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= st_start;
            alu_op      <= alu_add;
            alu_src_reg <= 1'b0;
            reg_write   <= 1'b0;
            pc_step     <= 1'b0;
            mem_req     <= 1'b0;
            load_select <= 1'b0;
            load_width  <= lw_word;
        end else begin
            case (state)
                st_start: begin
                    reg_write <= 1'b0;
                    pc_step   <= 1'b0;
                    if (is_r_type || is_i_type) begin
                        state       <= st_write_back;
                        alu_op      <= decoded_op;
                        alu_src_reg <= is_r_type;
                        load_select <= 1'b0;
                    end else if (is_load) begin
                        // Address is rs1 plus immediate.
                        state       <= st_mem_request;
                        alu_op      <= alu_add;
                        alu_src_reg <= 1'b0;
                        load_select <= 1'b1;
                        load_width  <= decoded_width;
                        mem_req     <= 1'b1;
                    end
                end
                st_write_back: begin
                    state     <= st_increment_pc;
                    reg_write <= 1'b1;
                end
                st_increment_pc: begin
                    state     <= st_complete;
                    reg_write <= 1'b0;
                    pc_step   <= 1'b1;
                end
                st_complete: begin
                    state   <= st_start;
                    pc_step <= 1'b0;
                end
                st_mem_request: begin
                    if (mem_ack) begin
                        state   <= st_mem_release;
                        mem_req <= 1'b0;
                    end
                end
                st_mem_release: begin
                    // Write back only once the responder has let go.
                    if (!mem_ack) begin
                        state     <= st_increment_pc;
                        reg_write <= 1'b1;
                    end
                end
                default: state <= st_start;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) $fell(mem_req) |-> $past(mem_ack));

    assert property (@(posedge clk) disable iff (!rst_n) !(reg_write && pc_step));

endmodule

//--- logic/cpu.sv
`include "rv_macros.svh"

module cpu (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`RV_XLEN-1:0]        instruction,
    input  logic                       mem_ack,
    input  logic [`RV_XLEN-1:0]        read_data,
    output logic [`RV_XLEN-1:0]        pc,
    output logic                       mem_req,
    output logic [`RV_DMEM_ADDR_W-1:0] mem_addr,
    output logic                       wb_valid,
    output logic [`RV_REG_ADDR_W-1:0]  wb_rd,
    output logic [`RV_XLEN-1:0]        wb_data
);
    import rv_pkg::*;

    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic                      funct7_sub;
    logic [`RV_REG_ADDR_W-1:0] rs1;
    logic [`RV_REG_ADDR_W-1:0] rs2;
    logic [`RV_REG_ADDR_W-1:0] rd;
    logic [`RV_XLEN-1:0]       immediate;
    logic [`RV_XLEN-1:0]       alu_result;
    alu_op_t                   alu_op;
    logic                      alu_src_reg;
    logic                      reg_write;
    logic                      pc_step;
    logic                      data_latch;
    logic                      load_select;
    load_width_t               load_width;
    logic [`RV_XLEN-1:0]       load_data;
    logic [`RV_XLEN-1:0]       load_value;

    // ************************************************************************
    // Field decode
    // ************************************************************************

    assign opcode     = instruction[6:0];
    assign rd         = instruction[11:7];
    assign funct3     = instruction[14:12];
    assign rs1        = instruction[19:15];
    assign rs2        = instruction[24:20];
    assign funct7_sub = instruction[30];

    // I-type immediate, zero-extended.
    assign immediate = {{(`RV_XLEN-12){1'b0}}, instruction[31:20]};

    datapath u_datapath (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_write   (reg_write),
        .alu_op      (alu_op),
        .alu_src_reg (alu_src_reg),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .write_data  (wb_data),
        .immediate   (immediate),
        .alu_result  (alu_result),
        .negative    (),
        .overflow    (),
        .zero        (),
        .rs2_data    ()
    );

    control_fsm u_control_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .opcode      (opcode),
        .funct3      (funct3),
        .funct7_sub  (funct7_sub),
        .mem_ack     (mem_ack),
        .alu_op      (alu_op),
        .alu_src_reg (alu_src_reg),
        .reg_write   (reg_write),
        .pc_step     (pc_step),
        .mem_req     (mem_req),
        .data_latch  (data_latch),
        .load_select (load_select),
        .load_width  (load_width)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pc_step) begin
            pc <= pc + `RV_XLEN'd4;
        end
    end

    // ************************************************************************
    // Memory side and write-back
    // ************************************************************************

    assign mem_addr = alu_result[`RV_DMEM_ADDR_W-1:0];

    always_ff @(posedge clk) begin
        if (data_latch) begin
            load_data <= read_data;
        end
    end

    always_comb begin
        case (load_width)
            lw_byte: load_value = {{(`RV_XLEN-8){1'b0}}, load_data[7:0]};
            lw_half: load_value = {{(`RV_XLEN-16){1'b0}}, load_data[15:0]};
            default: load_value = load_data;
        endcase
    end

    assign wb_data  = load_select ? load_value : alu_result;
    assign wb_valid = reg_write;
    assign wb_rd    = rd;

endmodule

//--- logic/datapath.sv
`include "rv_macros.svh"

module datapath (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      reg_write,
    input  rv_pkg::alu_op_t           alu_op,
    input  logic                      alu_src_reg,
    input  logic [`RV_REG_ADDR_W-1:0] rs1,
    input  logic [`RV_REG_ADDR_W-1:0] rs2,
    input  logic [`RV_REG_ADDR_W-1:0] rd,
    input  logic [`RV_XLEN-1:0]       write_data,
    input  logic [`RV_XLEN-1:0]       immediate,
    output logic [`RV_XLEN-1:0]       alu_result,
    output logic                      negative,
    output logic                      overflow,
    output logic                      zero,
    output logic [`RV_XLEN-1:0]       rs2_data
);

    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] operand_b;

    reg_bank u_reg_bank (
        .clk         (clk),
        .rst_n       (rst_n),
        .write_en    (reg_write),
        .read_addr_a (rs1),
        .read_addr_b (rs2),
        .write_addr  (rd),
        .write_data  (write_data),
        .read_data_a (rs1_data),
        .read_data_b (rs2_data)
    );

    // Second operand from the bank for R-type, else the immediate.
    assign operand_b = alu_src_reg ? rs2_data : immediate;

    alu u_alu (
        .op        (alu_op),
        .operand_a (rs1_data),
        .operand_b (operand_b),
        .result    (alu_result),
        .negative  (negative),
        .overflow  (overflow),
        .zero      (zero)
    );

endmodule

//--- logic/reg_bank.sv
`include "rv_macros.svh"

module reg_bank (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      write_en,
    input  logic [`RV_REG_ADDR_W-1:0] read_addr_a,
    input  logic [`RV_REG_ADDR_W-1:0] read_addr_b,
    input  logic [`RV_REG_ADDR_W-1:0] write_addr,
    input  logic [`RV_XLEN-1:0]       write_data,
    output logic [`RV_XLEN-1:0]       read_data_a,
    output logic [`RV_XLEN-1:0]       read_data_b
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    // Writes to x0 are dropped.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && (write_addr != '0)) begin
            regs[write_addr] <= write_data;
        end
    end

    // Both read ports are combinational.
    assign read_data_a = regs[read_addr_a];
    assign read_data_b = regs[read_addr_b];

    // x0 reads as zero on either port, whatever was written to it.
    assert property (@(posedge clk) disable iff (!rst_n)
        ((read_addr_a != '0) || (read_data_a == '0)) &&
        ((read_addr_b != '0) || (read_data_b == '0)));

endmodule

//--- logic/rv_pkg.sv
package rv_pkg;

    // ************************************************************************
    // ALU
    // ************************************************************************

    // Order matches nothing in the encoding; the FSM maps funct3 explicitly.
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_or,
        alu_and
    } alu_op_t;

    // ************************************************************************
    // Control
    // ************************************************************************

    typedef enum logic [2:0] {
        st_start,
        st_write_back,
        st_increment_pc,
        st_complete,
        st_mem_request,
        st_mem_release
    } ctrl_state_t;

    // Load size, always zero-extended.
    typedef enum logic [1:0] {
        lw_byte,
        lw_half,
        lw_word
    } load_width_t;

endpackage

//--- tb/rv_golden.sv
`include "rv_macros.svh"

module rv_golden;
    timeunit 1ns;
    timeprecision 1ps;

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];
    logic [`RV_XLEN-1:0] dmem [256];

    task automatic clear_registers();
        for (int i = 0; i < `RV_REG_COUNT; i++) begin
            regs[i] = '0;
        end
    endtask

    task automatic write_word(input int index, input logic [31:0] value);
        dmem[index] = value;
    endtask

    function automatic logic [31:0] read_word(input logic [7:0] index);
        return dmem[index];
    endfunction

    // Value an instruction sends to rd, from the registers before it retires.
    function automatic logic [31:0] predict(input logic [31:0] instr);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] word;
        logic [31:0] result;
        logic [9:0]  addr;
        imm = {20'd0, instr[31:20]};
        a = regs[instr[19:15]];
        b = (instr[6:0] == `RV_OPC_R_TYPE) ? regs[instr[24:20]] : imm;
        if (instr[6:0] == `RV_OPC_LOAD) begin
            addr = a[9:0] + imm[9:0];
            word = dmem[addr[9:2]];
            case (instr[14:12])
                3'd0:    result = {24'd0, word[7:0]};
                3'd1:    result = {16'd0, word[15:0]};
                default: result = word;
            endcase
        end else begin
            case (instr[14:12])
                3'd0:    result = (instr[6:0] == `RV_OPC_R_TYPE && instr[30]) ? a - b : a + b;
                3'd1:    result = a << b[4:0];
                3'd2:    result = {31'd0, ($signed(a) < $signed(b))};
                3'd3:    result = {31'd0, (a < b)};
                3'd4:    result = a ^ b;
                3'd5:    result = a >> b[4:0];
                3'd6:    result = a | b;
                default: result = a & b;
            endcase
        end
        return result;
    endfunction

    // x0 stays zero.
    task automatic retire(input logic [31:0] instr);
        logic [31:0] value;
        value = predict(instr);
        if (instr[11:7] != 5'd0) begin
            regs[instr[11:7]] = value;
        end
    endtask

endmodule

//--- tb/tb_cpu.sv
`include "rv_macros.svh"

module tb_cpu;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED       = 90;
    localparam int N_INSTR    = 256;
    localparam int CLK_PERIOD = 4;
    localparam int MAX_DELAY  = 5;
    // Slowest load per instruction, plus room for reset.
    localparam int TIMEOUT_CYCLES = N_INSTR * (4 + 2 * (MAX_DELAY + 1) + 2) + 100;

    logic        clk;
    logic        rst_n;
    logic [31:0] instruction;
    logic        mem_ack;
    logic [31:0] read_data;
    logic [31:0] pc;
    logic        mem_req;
    logic [9:0]  mem_addr;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;

    logic [31:0] imem [N_INSTR];
    int unsigned delays [2*N_INSTR];
    logic [31:0] last_pc   = '0;
    int          pulses    = 0;
    int          retired   = 0;
    int          cycles    = 0;
    logic        req_seen  = 1'b0;
    logic [9:0]  held_addr = '0;

    cpu dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instruction (instruction),
        .mem_ack     (mem_ack),
        .read_data   (read_data),
        .pc          (pc),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    rv_golden golden ();

    // Fetch is combinational on the current pc.
    assign instruction = rst_n ? imem[pc[9:2]] : '0;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Simulation FAILED");
            $display("Mismatch on %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $fatal(1, "Stopped at the first error.");
        end
    endtask

    // Loads always use x0 as base.
    function automatic logic [31:0] make_instruction();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic [2:0]  width;
        logic [11:0] imm;
        logic [6:0]  funct7;
        logic [31:0] instr;
        rd     = $urandom % 32;
        rs1    = $urandom % 32;
        rs2    = $urandom % 32;
        funct3 = $urandom % 8;
        width  = $urandom % 3;
        imm    = $urandom % 4096;
        funct7 = (funct3 == 3'd0 && ($urandom % 2) == 1) ? 7'h20 : 7'h00;
        case ($urandom % 3)
            0:       instr = {funct7, rs2, rs1, funct3, rd, `RV_OPC_R_TYPE};
            1:       instr = {imm, rs1, funct3, rd, `RV_OPC_I_TYPE};
            default: instr = {imm, 5'd0, width, rd, `RV_OPC_LOAD};
        endcase
        return instr;
    endfunction

    // ************************************************************************
    // Stimulus
    // ************************************************************************

    initial begin
        rst_n = 1'b0;
        void'($urandom(SEED));
        for (int i = 0; i < N_INSTR; i++) begin
            imem[i] = make_instruction();
        end
        for (int i = 0; i < 256; i++) begin
            golden.write_word(i, $urandom);
        end
        for (int i = 0; i < 2 * N_INSTR; i++) begin
            delays[i] = $urandom % (MAX_DELAY + 1);
        end
        golden.clear_registers();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n <= 1'b1;
        check_value("pc", pc, 32'd0);
        check_value("mem_req", mem_req, 32'd0);
        check_value("wb_valid", wb_valid, 32'd0);
        while (retired < N_INSTR) @(negedge clk);
        check_value("pc", pc, N_INSTR * 4);
        $display("Simulation PASSED");
        $finish;
    end

    // Data memory responder, each phase after a drawn delay.
    initial begin : responder
        int unsigned next_delay;
        next_delay = 0;
        mem_ack    = 1'b0;
        read_data  = '0;
        forever begin
            @(negedge clk);
            if (rst_n && mem_req && !mem_ack) begin
                repeat (delays[next_delay % (2 * N_INSTR)]) @(negedge clk);
                next_delay++;
                mem_ack   <= 1'b1;
                read_data <= golden.read_word(mem_addr[9:2]);
                do begin
                    @(negedge clk);
                end while (mem_req);
                repeat (delays[next_delay % (2 * N_INSTR)]) @(negedge clk);
                next_delay++;
                mem_ack <= 1'b0;
            end
        end
    end

    // ************************************************************************
    // Monitor
    // ************************************************************************

    // The instruction in flight is the one at the expected pc.
    always @(negedge clk) begin
        logic [31:0] expected_instr;
        expected_instr = imem[last_pc[9:2]];
        if (rst_n) begin
            if (wb_valid) begin
                check_value("wb_valid count", pulses, 32'd0);
                check_value("wb_valid in handshake", mem_req | mem_ack, 32'd0);
                check_value("wb_rd", wb_rd, expected_instr[11:7]);
                check_value("wb_data", wb_data, golden.predict(expected_instr));
                golden.retire(expected_instr);
                pulses++;
            end
            if (pc !== last_pc) begin
                check_value("pc", pc, last_pc + 32'd4);
                check_value("wb_valid count", pulses, 32'd1);
                pulses  = 0;
                retired++;
                last_pc = pc;
            end
            // Address held for the whole request phase.
            if (mem_req) begin
                check_value("mem_addr", mem_addr, expected_instr[29:20]);
                if (req_seen) begin
                    check_value("mem_addr", mem_addr, held_addr);
                end
                held_addr = mem_addr;
            end
            req_seen = mem_req;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Simulation FAILED");
            $display("Timeout after %0d cycles, %0d of %0d instructions retired",
                     cycles, retired, N_INSTR);
            $fatal(1, "Run stopped by the cycle limit.");
        end
    end

endmodule

//--- verilog.f
+incdir+include
logic/rv_pkg.sv
logic/reg_bank.sv
logic/alu.sv
logic/datapath.sv
logic/control_fsm.sv
logic/cpu.sv
tb/rv_golden.sv
tb/tb_cpu.sv
